/* build.f */
source/mem_pkg.sv
source/mem_access_decode.sv
source/mem_byte_sequencer.sv
source/load_result_assembler.sv
source/byte_ram.sv
source/mem_stage_top.sv
testbench/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module tb_mem_stage --Mdir obj_dir -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
exit 1

/* testbench/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    // 20 cycles per byte transfer (224 with random ops at 4 bytes) and per op (63) plus reset
    localparam int MAX_CYCLES = 20 * (224 + 63) + 16;

    logic               clk;
    logic               rst;
    logic               op_req_i;
    mem_pkg::alu_op_e   aluop_i;
    logic [7:0]         addr_i;
    logic [31:0]        store_data_i;
    logic [31:0]        wdata_i;
    logic [4:0]         rd_i;
    logic               wreg_i;
    logic               op_ack_o;
    logic [31:0]        wdata_o;
    logic [4:0]         rd_o;
    logic               wreg_o;

    logic [7:0]         ref_mem [256];  // reference byte memory
    bit                 known [256];    // byte has been written
    int                 errors;
    int                 cycles;
    integer             seed;

    mem_stage_top UUT (
        .clk          (clk),
        .rst          (rst),
        .op_req_i     (op_req_i),
        .aluop_i      (aluop_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .wdata_i      (wdata_i),
        .rd_i         (rd_i),
        .wreg_i       (wreg_i),
        .op_ack_o     (op_ack_o),
        .wdata_o      (wdata_o),
        .rd_o         (rd_o),
        .wreg_o       (wreg_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int op_bytes(input mem_pkg::alu_op_e op);
        case (op)
            mem_pkg::EXE_LB_OP, mem_pkg::EXE_LBU_OP, mem_pkg::EXE_SB_OP: return 1;
            mem_pkg::EXE_LH_OP, mem_pkg::EXE_LHU_OP, mem_pkg::EXE_SH_OP: return 2;
            mem_pkg::EXE_LW_OP, mem_pkg::EXE_SW_OP:                      return 4;
            default:                                                     return 0;
        endcase
    endfunction

    function automatic bit is_load_op(input mem_pkg::alu_op_e op);
        return op inside {mem_pkg::EXE_LB_OP, mem_pkg::EXE_LH_OP, mem_pkg::EXE_LW_OP,
                          mem_pkg::EXE_LBU_OP, mem_pkg::EXE_LHU_OP};
    endfunction

    function automatic bit is_store_op(input mem_pkg::alu_op_e op);
        return op inside {mem_pkg::EXE_SB_OP, mem_pkg::EXE_SH_OP, mem_pkg::EXE_SW_OP};
    endfunction

    function automatic bit bytes_known(input mem_pkg::alu_op_e op, input logic [7:0] addr);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < op_bytes(op); i++) begin
            ok = ok & known[addr + 8'(i)];
        end
        return ok;
    endfunction

    // little-endian assembly from the model and extension by opcode
    function automatic logic [31:0] expected_load(input mem_pkg::alu_op_e op,
                                                  input logic [7:0] addr);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < op_bytes(op); i++) begin
            value[8*i +: 8] = ref_mem[addr + 8'(i)];
        end
        if (op == mem_pkg::EXE_LB_OP) begin
            value = {{24{value[7]}}, value[7:0]};
        end else if (op == mem_pkg::EXE_LH_OP) begin
            value = {{16{value[15]}}, value[15:0]};
        end
        return value;
    endfunction

    task automatic record_store(input mem_pkg::alu_op_e op, input logic [7:0] addr,
                                input logic [31:0] data);
        for (int i = 0; i < op_bytes(op); i++) begin
            ref_mem[addr + 8'(i)] = data[8*i +: 8];
            known[addr + 8'(i)]   = 1'b1;
        end
    endtask

    function automatic mem_pkg::alu_op_e pick_op(input int idx);
        case (idx)
            0:       return mem_pkg::EXE_NOP_OP;
            1:       return mem_pkg::EXE_ADD_OP;
            2:       return mem_pkg::EXE_LB_OP;
            3:       return mem_pkg::EXE_LH_OP;
            4:       return mem_pkg::EXE_LW_OP;
            5:       return mem_pkg::EXE_LBU_OP;
            6:       return mem_pkg::EXE_LHU_OP;
            7:       return mem_pkg::EXE_SB_OP;
            8:       return mem_pkg::EXE_SH_OP;
            default: return mem_pkg::EXE_SW_OP;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // full four-phase handshake on the upstream port
    task automatic do_op(input mem_pkg::alu_op_e op, input logic [7:0] addr,
                         input logic [31:0] sdata, input logic [31:0] wdata,
                         input logic [4:0] rd, input logic wreg,
                         output logic [31:0] wdata_out, output logic [4:0] rd_out,
                         output logic wreg_out);
        @(posedge clk);
        aluop_i      <= op;
        addr_i       <= addr;
        store_data_i <= sdata;
        wdata_i      <= wdata;
        rd_i         <= rd;
        wreg_i       <= wreg;
        op_req_i     <= 1'b1;
        do @(negedge clk); while (!op_ack_o);
        wdata_out = wdata_o;
        rd_out    = rd_o;
        wreg_out  = wreg_o;
        @(posedge clk);
        op_req_i <= 1'b0;
        do @(negedge clk); while (op_ack_o);
    endtask

    task automatic run_check(input mem_pkg::alu_op_e op, input logic [7:0] addr,
                             input logic [31:0] sdata, input logic [31:0] wdata,
                             input logic [4:0] rd, input logic wreg);
        logic [31:0] exp_wdata;
        logic        exp_wreg;
        logic [31:0] got_wdata;
        logic [4:0]  got_rd;
        logic        got_wreg;
        exp_wdata = is_load_op(op) ? expected_load(op, addr) : wdata;
        exp_wreg  = is_store_op(op) ? 1'b0 : wreg;
        do_op(op, addr, sdata, wdata, rd, wreg, got_wdata, got_rd, got_wreg);
        check_value("wdata_o", exp_wdata, got_wdata);
        check_value("rd_o", 32'(rd), 32'(got_rd));
        check_value("wreg_o", 32'(exp_wreg), 32'(got_wreg));
        if (is_store_op(op)) begin
            record_store(op, addr, sdata);
        end
    endtask

    task automatic reset_passthrough();
        check_value("op_ack_o", 32'd0, 32'(op_ack_o));
        check_value("wreg_o", 32'd0, 32'(wreg_o));
        run_check(mem_pkg::EXE_ADD_OP, 8'h00, 32'h0, 32'hcafe_f00d, 5'd7, 1'b1);
        run_check(mem_pkg::EXE_ADD_OP, 8'h5a, 32'h1, 32'h0000_1234, 5'd31, 1'b0);
    endtask

    task automatic word_round_trip();
        run_check(mem_pkg::EXE_SW_OP, 8'h10, 32'h1234_5678, 32'h10, 5'd3, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'h10, 32'h0, 32'h10, 5'd4, 1'b1);
    endtask

    task automatic byte_lanes();
        run_check(mem_pkg::EXE_SW_OP, 8'h20, 32'h0102_0304, 32'h20, 5'd1, 1'b1);
        run_check(mem_pkg::EXE_SB_OP, 8'h20, 32'hdead_beaa, 32'h20, 5'd2, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'h20, 32'h0, 32'h20, 5'd5, 1'b1);
        run_check(mem_pkg::EXE_SH_OP, 8'h21, 32'h1234_beef, 32'h21, 5'd6, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'h20, 32'h0, 32'h20, 5'd8, 1'b1);
    endtask

    task automatic sign_extension();
        run_check(mem_pkg::EXE_SW_OP, 8'h30, 32'h7f80_85c3, 32'h30, 5'd9, 1'b1);
        run_check(mem_pkg::EXE_LB_OP, 8'h30, 32'h0, 32'h30, 5'd10, 1'b1);
        run_check(mem_pkg::EXE_LBU_OP, 8'h30, 32'h0, 32'h30, 5'd11, 1'b1);
        run_check(mem_pkg::EXE_LH_OP, 8'h30, 32'h0, 32'h30, 5'd12, 1'b1);
        run_check(mem_pkg::EXE_LHU_OP, 8'h30, 32'h0, 32'h30, 5'd13, 1'b1);
        run_check(mem_pkg::EXE_LB_OP, 8'h33, 32'h0, 32'h33, 5'd14, 1'b1);  // positive byte
        run_check(mem_pkg::EXE_LH_OP, 8'h32, 32'h0, 32'h32, 5'd15, 1'b1);
    endtask

    task automatic address_wrap();
        run_check(mem_pkg::EXE_SW_OP, 8'd249, 32'h5566_7788, 32'h0, 5'd16, 1'b1);
        run_check(mem_pkg::EXE_SW_OP, 8'd1, 32'h99aa_bbcc, 32'h0, 5'd17, 1'b1);
        run_check(mem_pkg::EXE_SW_OP, 8'd253, 32'ha1b2_c3d4, 32'h0, 5'd18, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'd253, 32'h0, 32'h0, 5'd19, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'd249, 32'h0, 32'h0, 5'd20, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'd1, 32'h0, 32'h0, 5'd21, 1'b1);
        run_check(mem_pkg::EXE_LW_OP, 8'd254, 32'h0, 32'h0, 5'd22, 1'b1);  // 254..1
    endtask

    task automatic random_mix();
        mem_pkg::alu_op_e op;
        logic [7:0]       addr;
        for (int n = 0; n < 40; n++) begin
            op   = pick_op(int'($unsigned($random(seed)) % 10));
            addr = 8'($random(seed));
            if (is_load_op(op) && !bytes_known(op, addr)) begin
                op = mem_pkg::EXE_SW_OP;  // store to bytes that are still unwritten
            end
            run_check(op, addr, 32'($random(seed)), 32'($random(seed)),
                      5'($random(seed)), 1'($random(seed)));
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles <= MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the handshake did not complete within %0d cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        errors       = 0;
        seed         = 91173;
        rst          = 1'b1;
        op_req_i     = 1'b0;
        aluop_i      = mem_pkg::EXE_NOP_OP;
        addr_i       = '0;
        store_data_i = '0;
        wdata_i      = '0;
        rd_i         = '0;
        wreg_i       = 1'b0;
        for (int i = 0; i < 256; i++) begin
            known[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_passthrough();
        word_round_trip();
        byte_lanes();
        sign_extension();
        address_wrap();
        random_mix();
        $display("errors: %0d mismatches after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                op_req_i,
    input  wire mem_pkg::alu_op_e              aluop_i,
    input  wire [mem_pkg::RAM_ADDR_W-1:0]      addr_i,
    input  wire [mem_pkg::REG_W-1:0]           store_data_i,
    input  wire [mem_pkg::REG_W-1:0]           wdata_i,
    input  wire [mem_pkg::REG_ADDR_W-1:0]      rd_i,
    input  wire                                wreg_i,
    output logic                               op_ack_o,
    output logic [mem_pkg::REG_W-1:0]          wdata_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic                               wreg_o
);

    logic                              is_load;
    logic                              is_store;
    logic                              sign_ext;
    mem_pkg::mem_size_e                size;
    logic                              op_start;
    logic                              op_done;
    logic                              bus_req;
    logic                              bus_we;
    logic                              bus_ack;
    logic [mem_pkg::RAM_ADDR_W-1:0]    bus_addr;
    logic [7:0]                        bus_wdata;
    logic [7:0]                        bus_rdata;
    logic                              byte_valid;
    logic [mem_pkg::BYTE_IDX_W-1:0]    byte_idx;

    mem_access_decode u_decode (
        .aluop_i    (aluop_i),
        .is_load_o  (is_load),
        .is_store_o (is_store),
        .sign_ext_o (sign_ext),
        .size_o     (size)
    );

    mem_byte_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .op_req_i     (op_req_i),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .size_i       (size),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .bus_ack_i    (bus_ack),
        .op_ack_o     (op_ack_o),
        .op_start_o   (op_start),
        .op_done_o    (op_done),
        .bus_req_o    (bus_req),
        .bus_we_o     (bus_we),
        .bus_addr_o   (bus_addr),
        .bus_wdata_o  (bus_wdata),
        .byte_valid_o (byte_valid),
        .byte_idx_o   (byte_idx)
    );

    load_result_assembler u_asm (
        .clk          (clk),
        .rst          (rst),
        .op_start_i   (op_start),
        .op_done_i    (op_done),
        .byte_valid_i (byte_valid),
        .byte_idx_i   (byte_idx),
        .byte_data_i  (bus_rdata),
        .is_load_i    (is_load),
        .sign_ext_i   (sign_ext),
        .size_i       (size),
        .wdata_i      (wdata_i),
        .rd_i         (rd_i),
        .wreg_i       (wreg_i & ~is_store),  // stores never write rd
        .wdata_o      (wdata_o),
        .rd_o         (rd_o),
        .wreg_o       (wreg_o)
    );

    byte_ram u_ram (
        .clk         (clk),
        .rst         (rst),
        .bus_req_i   (bus_req),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_ack_o   (bus_ack),
        .bus_rdata_o (bus_rdata)
    );

endmodule

`default_nettype wire

/* source/byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              bus_req_i,
    input  wire                              bus_we_i,
    input  wire [mem_pkg::RAM_ADDR_W-1:0]    bus_addr_i,
    input  wire [7:0]                        bus_wdata_i,
    output logic                             bus_ack_o,
    output logic [7:0]                       bus_rdata_o
);

    localparam int DEPTH = 1 << mem_pkg::RAM_ADDR_W;

    logic [7:0] mem [DEPTH];

    logic start;

    assign start = bus_req_i && !bus_ack_o;  // new request this cycle

    always_ff @(posedge clk) begin
        if (start) begin
            if (bus_we_i) begin
                mem[bus_addr_i] <= bus_wdata_i;
            end else begin
                bus_rdata_o <= mem[bus_addr_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_ack_o <= 1'b0;
        end else if (start) begin
            bus_ack_o <= 1'b1;
        end else if (!bus_req_i) begin
            bus_ack_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/load_result_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module load_result_assembler (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                op_start_i,
    input  wire                                op_done_i,
    input  wire                                byte_valid_i,
    input  wire [mem_pkg::BYTE_IDX_W-1:0]      byte_idx_i,
    input  wire [7:0]                          byte_data_i,
    input  wire                                is_load_i,
    input  wire                                sign_ext_i,
    input  wire mem_pkg::mem_size_e            size_i,
    input  wire [mem_pkg::REG_W-1:0]           wdata_i,
    input  wire [mem_pkg::REG_ADDR_W-1:0]      rd_i,
    input  wire                                wreg_i,
    output logic [mem_pkg::REG_W-1:0]          wdata_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]     rd_o,
    output logic                               wreg_o
);

    logic [mem_pkg::REG_W-1:0]       collect_q;
    logic [mem_pkg::REG_W-1:0]       wdata_q;
    logic [mem_pkg::REG_W-1:0]       load_val;
    logic [mem_pkg::REG_ADDR_W-1:0]  rd_q;
    logic                            sign_q;
    logic                            load_q;
    logic                            wreg_q;
    mem_pkg::mem_size_e              size_q;

    always_comb begin
        case (size_q)
            mem_pkg::MEM_BYTE:
                load_val = {{(mem_pkg::REG_W-8){sign_q & collect_q[7]}}, collect_q[7:0]};
            mem_pkg::MEM_HALF:
                load_val = {{(mem_pkg::REG_W-16){sign_q & collect_q[15]}}, collect_q[15:0]};
            default:
                load_val = collect_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (op_start_i) begin
            collect_q <= '0;
            wdata_q   <= wdata_i;
            rd_q      <= rd_i;
            sign_q    <= sign_ext_i;
            size_q    <= size_i;
        end else if (byte_valid_i) begin
            collect_q[{byte_idx_i, 3'b000} +: 8] <= byte_data_i;  // little-endian lane
        end
        if (op_done_i) begin
            wdata_o <= load_q ? load_val : wdata_q;
            rd_o    <= rd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= 1'b0;
            wreg_q <= 1'b0;
            wreg_o <= 1'b0;
        end else begin
            if (op_start_i) begin
                load_q <= is_load_i;
                wreg_q <= wreg_i;  // already gated off for stores
            end
            if (op_done_i) begin
                wreg_o <= wreg_q;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_byte_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_byte_sequencer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                op_req_i,
    input  wire                                is_load_i,
    input  wire                                is_store_i,
    input  wire mem_pkg::mem_size_e            size_i,
    input  wire [mem_pkg::RAM_ADDR_W-1:0]      addr_i,
    input  wire [mem_pkg::REG_W-1:0]           store_data_i,
    input  wire                                bus_ack_i,
    output logic                               op_ack_o,
    output logic                               op_start_o,
    output logic                               op_done_o,
    output logic                               bus_req_o,
    output logic                               bus_we_o,
    output logic [mem_pkg::RAM_ADDR_W-1:0]     bus_addr_o,
    output logic [7:0]                         bus_wdata_o,
    output logic                               byte_valid_o,
    output logic [mem_pkg::BYTE_IDX_W-1:0]     byte_idx_o
);

    mem_pkg::seq_state_e                 state;
    logic                                load_q;
    logic [mem_pkg::RAM_ADDR_W-1:0]      addr_q;
    logic [mem_pkg::REG_W-1:0]           store_q;
    logic [mem_pkg::BYTE_IDX_W-1:0]      last_idx_q;

    assign bus_addr_o  = addr_q + mem_pkg::RAM_ADDR_W'(byte_idx_o);  // wraps in ram depth
    assign bus_wdata_o = store_q[{byte_idx_o, 3'b000} +: 8];

    // operation payload, taken when a request is accepted
    always_ff @(posedge clk) begin
        if (state == mem_pkg::S_IDLE && op_req_i) begin
            addr_q  <= addr_i;
            store_q <= store_data_i;
            case (size_i)
                mem_pkg::MEM_BYTE: last_idx_q <= 2'd0;
                mem_pkg::MEM_HALF: last_idx_q <= 2'd1;
                default:           last_idx_q <= 2'd3;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mem_pkg::S_IDLE;
            op_ack_o     <= 1'b0;
            op_start_o   <= 1'b0;
            op_done_o    <= 1'b0;
            bus_req_o    <= 1'b0;
            bus_we_o     <= 1'b0;
            load_q       <= 1'b0;
            byte_valid_o <= 1'b0;
            byte_idx_o   <= '0;
        end else begin
            op_start_o   <= 1'b0;
            byte_valid_o <= 1'b0;
            case (state)
                mem_pkg::S_IDLE: begin
                    if (op_req_i) begin
                        op_start_o <= 1'b1;
                        byte_idx_o <= '0;
                        bus_we_o   <= is_store_i;
                        load_q     <= is_load_i;
                        if (is_load_i || is_store_i) begin
                            bus_req_o <= 1'b1;
                            state     <= mem_pkg::S_BUS_REQ;
                        end else begin
                            state <= mem_pkg::S_OP_ACK;
                        end
                    end
                end
                mem_pkg::S_BUS_REQ: begin
                    if (bus_ack_i) begin
                        bus_req_o    <= 1'b0;
                        byte_valid_o <= load_q;  // rdata still valid next cycle
                        state        <= mem_pkg::S_BUS_RELEASE;
                    end
                end
                mem_pkg::S_BUS_RELEASE: begin
                    if (!bus_ack_i) begin
                        if (byte_idx_o == last_idx_q) begin
                            state <= mem_pkg::S_OP_ACK;
                        end else begin
                            byte_idx_o <= byte_idx_o + 1'b1;
                            bus_req_o  <= 1'b1;
                            state      <= mem_pkg::S_BUS_REQ;
                        end
                    end
                end
                mem_pkg::S_OP_ACK: begin
                    // done first, ack once the assembler has registered
                    op_done_o <= !op_ack_o && !op_done_o;
                    if (op_done_o) begin
                        op_ack_o <= 1'b1;
                    end else if (op_ack_o && !op_req_i) begin
                        op_ack_o <= 1'b0;
                        state    <= mem_pkg::S_IDLE;
                    end
                end
                default: state <= mem_pkg::S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/mem_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_decode (
    input  wire mem_pkg::alu_op_e   aluop_i,
    output logic                    is_load_o,
    output logic                    is_store_o,
    output logic                    sign_ext_o,
    output mem_pkg::mem_size_e      size_o
);

    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        sign_ext_o = 1'b0;
        size_o     = mem_pkg::MEM_WORD;
        case (aluop_i)
            mem_pkg::EXE_LB_OP: begin
                is_load_o  = 1'b1;
                sign_ext_o = 1'b1;
                size_o     = mem_pkg::MEM_BYTE;
            end
            mem_pkg::EXE_LH_OP: begin
                is_load_o  = 1'b1;
                sign_ext_o = 1'b1;
                size_o     = mem_pkg::MEM_HALF;
            end
            mem_pkg::EXE_LW_OP: begin
                is_load_o = 1'b1;
            end
            mem_pkg::EXE_LBU_OP: begin
                is_load_o = 1'b1;
                size_o    = mem_pkg::MEM_BYTE;
            end
            mem_pkg::EXE_LHU_OP: begin
                is_load_o = 1'b1;
                size_o    = mem_pkg::MEM_HALF;
            end
            mem_pkg::EXE_SB_OP: begin
                is_store_o = 1'b1;
                size_o     = mem_pkg::MEM_BYTE;
            end
            mem_pkg::EXE_SH_OP: begin
                is_store_o = 1'b1;
                size_o     = mem_pkg::MEM_HALF;
            end
            mem_pkg::EXE_SW_OP: begin
                is_store_o = 1'b1;
            end
            default: ;  // alu ops pass through untouched
        endcase
    end

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int RAM_ADDR_W = 8;   // 256 bytes
    localparam int BYTE_IDX_W = 2;

    typedef enum logic [7:0] {
        EXE_NOP_OP = 8'h00,
        EXE_ADD_OP = 8'h01,  // any non-memory op
        EXE_LB_OP  = 8'h10,
        EXE_LH_OP  = 8'h11,
        EXE_LW_OP  = 8'h12,
        EXE_LBU_OP = 8'h13,
        EXE_LHU_OP = 8'h14,
        EXE_SB_OP  = 8'h18,
        EXE_SH_OP  = 8'h19,
        EXE_SW_OP  = 8'h1a
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        S_IDLE        = 2'd0,
        S_BUS_REQ     = 2'd1,
        S_BUS_RELEASE = 2'd2,
        S_OP_ACK      = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire
